/* all.f */
source/crc_bus_pkg.sv
source/crc_cfg_pkg.sv
source/host_interface.sv
source/crc_data_buffer.sv
source/crc_core.sv
source/crc_ahb.sv
bench/clock_gen.sv
bench/crc_ahb_chk.sv
bench/crc_ahb_tb.sv

/* bench/clock_gen.sv */
// Clock of period 100 and a synchronous active-low reset held for 4 cycles
module clock_gen
(
	output logic HCLK,
	output logic HRESETn
);

	initial
	begin
		HCLK = 1'b0;
		forever #50 HCLK = ~HCLK;
	end

	// Released a short time after the fourth rising edge
	initial
	begin
		HRESETn = 1'b0;
		repeat (4) @(posedge HCLK);
		#10;
		HRESETn = 1'b1;
	end

endmodule

/* bench/crc_ahb_chk.sv */
// Handshake and reset checks, bound into host_interface
// Signal names follow the internals of host_interface
module crc_ahb_chk
(
	input logic HCLK,
	input logic HRESETn,
	input logic HREADYOUT,
	input logic HRESP,
	input logic active,
	input logic write_en,
	input logic dr_sel,
	input logic buffer_full,
	input logic buffer_write_en,
	input logic crc_init_en,
	input logic crc_poly_en,
	input logic crc_idr_en,
	input logic reset_chain
);

	logic any_strobe;

	// Any register write strobe, chain reset included
	assign any_strobe = buffer_write_en || crc_init_en || crc_poly_en ||
	                    crc_idr_en || reset_chain;

	hresp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
		HRESP == crc_bus_pkg::HRESP_OKAY)
		else $error("HRESP is not OKAY");

	// Strobes only in the completing data-phase cycle
	no_strobe_in_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
		!HREADYOUT |-> !any_strobe)
		else $error("Write strobe raised during a wait state");

	full_buffer_stalls: assert property (@(posedge HCLK) disable iff (!HRESETn)
		(write_en && dr_sel && buffer_full) |-> !HREADYOUT)
		else $error("DR write completed into a full buffer");

	idle_is_ready: assert property (@(posedge HCLK) disable iff (!HRESETn)
		!active |-> HREADYOUT)
		else $error("Wait state without a transfer in its data phase");

	// First cycle out of reset
	ready_after_reset: assert property (@(posedge HCLK)
		$rose(HRESETn) |-> (HREADYOUT && !any_strobe))
		else $error("Bus not idle after reset");

endmodule

/* bench/crc_ahb_tb.sv */
// Self-checking testbench for the AHB-Lite CRC peripheral
// Single NONSEQ transfers at word-aligned addresses, stops at the first mismatch
module crc_ahb_tb;

	// Inputs change this long after the rising edge
	localparam int DRIVE_DELAY = 10;
	// About 140 transfers and a DR read stalls at most about 6 cycles
	localparam int MAX_TRANSFERS = 160;
	localparam int WORST_STALL = 6;
	localparam int CYCLE_LIMIT = MAX_TRANSFERS * (WORST_STALL + 2) + 100;

	logic HCLK;
	logic HRESETn;
	logic HSEL;
	crc_bus_pkg::bus_word_t HADDR;
	crc_bus_pkg::htrans_t HTRANS;
	crc_bus_pkg::hsize_t HSIZE;
	logic HWRITE;
	crc_bus_pkg::bus_word_t HWDATA;
	logic HREADY;
	crc_bus_pkg::bus_word_t HRDATA;
	logic HREADYOUT;
	logic HRESP;

	// Reference model state
	crc_cfg_pkg::crc_word_t model_crc;
	crc_cfg_pkg::crc_word_t model_init;
	crc_cfg_pkg::crc_word_t model_poly;
	crc_cfg_pkg::crc_cfg_t model_cfg;

	integer seed;
	int cycles = 0;
	int error_count = 0;

	// Completed reads waiting for the compare process
	crc_bus_pkg::bus_word_t got_q[$];
	crc_bus_pkg::bus_word_t exp_q[$];
	string what_q[$];

	clock_gen clock_gen_i (.HCLK(HCLK), .HRESETn(HRESETn));

	crc_ahb crc_ahb_i (.*);

	bind host_interface crc_ahb_chk crc_ahb_chk_i (.*);

	// Only slave on the bus
	assign HREADY = HREADYOUT;

	////////////////////
	// Reference model

	function automatic int poly_width(input crc_cfg_pkg::poly_size_e size);
		case (size)
			crc_cfg_pkg::P16: return 16;
			crc_cfg_pkg::P8:  return 8;
			crc_cfg_pkg::P7:  return 7;
			default:          return 32;
		endcase
	endfunction

	// DR view is the low width bits, mirrored when rev_out is set
	function automatic crc_bus_pkg::bus_word_t out_view(input crc_cfg_pkg::crc_word_t crc,
		input crc_cfg_pkg::crc_cfg_t cfg);
		crc_bus_pkg::bus_word_t r;
		int width;
		width = poly_width(cfg.poly_size);
		r = '0;
		for (int i = 0; i < width; i++)
			r[i] = cfg.rev_out ? crc[width - 1 - i] : crc[i];
		return r;
	endfunction

	// Folds one written value in, returns the DR value and the next CRC
	function automatic crc_bus_pkg::bus_word_t crc_ref(input crc_cfg_pkg::crc_word_t crc,
		input crc_cfg_pkg::crc_cfg_t cfg, input crc_cfg_pkg::crc_word_t poly,
		input crc_bus_pkg::bus_word_t value, input crc_bus_pkg::hsize_t size,
		output crc_cfg_pkg::crc_word_t next_crc);
		crc_cfg_pkg::crc_word_t mask;
		crc_cfg_pkg::crc_word_t c;
		logic [31:0] v;
		logic fb;
		int width;
		int nbits;
		int unit;
		width = poly_width(cfg.poly_size);
		mask  = 32'hFFFF_FFFF >> (32 - width);
		nbits = (size == crc_bus_pkg::BYTE) ? 8 : (size == crc_bus_pkg::HALF) ? 16 : 32;
		case (cfg.rev_in)
			crc_cfg_pkg::BYTE: unit = 8;
			crc_cfg_pkg::HALF: unit = 16;
			crc_cfg_pkg::WORD: unit = 32;
			default:           unit = 1;
		endcase
		// Reversal unit never wider than the written data
		if (unit > nbits)
			unit = nbits;
		v = '0;
		for (int i = 0; i < nbits; i++)
			v[i] = value[(i / unit) * unit + (unit - 1 - i % unit)];
		// Most significant byte and bit go in first
		c = crc & mask;
		for (int i = nbits - 1; i >= 0; i--)
		begin
			fb = c[width - 1] ^ v[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		next_crc = c;
		return out_view(c, cfg);
	endfunction

	function automatic crc_cfg_pkg::crc_cfg_t make_cfg(input crc_cfg_pkg::poly_size_e ps,
		input crc_cfg_pkg::rev_in_e ri, input logic ro);
		crc_cfg_pkg::crc_cfg_t cfg;
		cfg.poly_size = ps;
		cfg.rev_in    = ri;
		cfg.rev_out   = ro;
		return cfg;
	endfunction

	// CR layout with reset at 0, poly size at 4:3, rev_in at 6:5 and rev_out at 7
	function automatic crc_bus_pkg::bus_word_t cr_word(input crc_cfg_pkg::crc_cfg_t cfg,
		input logic reset);
		crc_bus_pkg::bus_word_t w;
		w      = '0;
		w[0]   = reset;
		w[4:3] = cfg.poly_size;
		w[6:5] = cfg.rev_in;
		w[7]   = cfg.rev_out;
		return w;
	endfunction

	function automatic crc_bus_pkg::hsize_t random_size();
		logic [31:0] r;
		r = $random(seed);
		case (r[1:0])
			2'd0:    return crc_bus_pkg::BYTE;
			2'd1:    return crc_bus_pkg::HALF;
			default: return crc_bus_pkg::WORD;
		endcase
	endfunction

	////////////////////
	// Checking

	task automatic check_equal(input crc_bus_pkg::bus_word_t actual,
		input crc_bus_pkg::bus_word_t expected, input string what);
		if (actual !== expected)
		begin
			error_count++;
			$display("** Error at time %0t: %s read %h, expected %h",
				$time, what, actual, expected);
			$display("Test failures found");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	always @(posedge HCLK)
	begin
		while (got_q.size() > 0)
			check_equal(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
	end

	always @(posedge HCLK)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Test failures found");
			$fatal(1, "Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
		end
	end

	////////////////////
	// Bus master

	// Waits for a cycle ending with HREADYOUT high, samples before the edge
	task automatic wait_ready(output crc_bus_pkg::bus_word_t rdata);
		@(negedge HCLK);
		while (!HREADYOUT)
			@(negedge HCLK);
		rdata = HRDATA;
		// Every completing cycle answers OKAY
		check_equal({31'h0, HRESP}, 32'h0, "HRESP");
		@(posedge HCLK);
		#DRIVE_DELAY;
	endtask

	task automatic bus_transfer(input logic write, input crc_bus_pkg::reg_addr_t addr,
		input crc_bus_pkg::hsize_t size, input crc_bus_pkg::bus_word_t wdata,
		output crc_bus_pkg::bus_word_t rdata);
		crc_bus_pkg::bus_word_t unused;
		HSEL   = 1'b1;
		HADDR  = {27'h0, addr, 2'b00};
		HTRANS = crc_bus_pkg::NONSEQ;
		HSIZE  = size;
		HWRITE = write;
		wait_ready(unused);
		// Data phase with the bus idle behind it
		HSEL   = 1'b0;
		HTRANS = crc_bus_pkg::IDLE;
		HWRITE = 1'b0;
		HWDATA = write ? wdata : 32'h0;
		wait_ready(rdata);
	endtask

	task automatic write_reg(input crc_bus_pkg::reg_addr_t addr,
		input crc_bus_pkg::hsize_t size, input crc_bus_pkg::bus_word_t data);
		crc_bus_pkg::bus_word_t unused;
		bus_transfer(1'b1, addr, size, data, unused);
	endtask

	task automatic read_expect(input crc_bus_pkg::reg_addr_t addr,
		input crc_bus_pkg::bus_word_t expected, input string what);
		crc_bus_pkg::bus_word_t got;
		bus_transfer(1'b0, addr, crc_bus_pkg::WORD, 32'h0, got);
		got_q.push_back(got);
		exp_q.push_back(expected);
		what_q.push_back(what);
	endtask

	task automatic write_data(input crc_bus_pkg::bus_word_t value,
		input crc_bus_pkg::hsize_t size);
		crc_bus_pkg::bus_word_t unused;
		unused = crc_ref(model_crc, model_cfg, model_poly, value, size, model_crc);
		write_reg(crc_bus_pkg::REG_DR, size, value);
	endtask

	task automatic write_cfg(input crc_cfg_pkg::crc_cfg_t cfg);
		write_reg(crc_bus_pkg::REG_CR, crc_bus_pkg::WORD, cr_word(cfg, 1'b0));
		model_cfg = cfg;
	endtask

	// INIT write also restarts the CRC
	task automatic write_init(input crc_bus_pkg::bus_word_t value);
		write_reg(crc_bus_pkg::REG_INIT, crc_bus_pkg::WORD, value);
		model_init = value;
		model_crc  = value;
	endtask

	task automatic write_poly(input crc_bus_pkg::bus_word_t value);
		write_reg(crc_bus_pkg::REG_POL, crc_bus_pkg::WORD, value);
		model_poly = value;
	endtask

	////////////////////
	// Stimulus

	initial
	begin
		crc_bus_pkg::bus_word_t r;
		seed   = 25;
		HSEL   = 1'b0;
		HADDR  = '0;
		HTRANS = crc_bus_pkg::IDLE;
		HSIZE  = crc_bus_pkg::WORD;
		HWRITE = 1'b0;
		HWDATA = '0;
		model_crc  = 32'hFFFF_FFFF;
		model_init = 32'hFFFF_FFFF;
		model_poly = 32'h04C1_1DB7;
		model_cfg  = make_cfg(crc_cfg_pkg::P32, crc_cfg_pkg::NONE, 1'b0);
		@(posedge HRESETn);
		@(posedge HCLK);
		#DRIVE_DELAY;

		// Reset values and register read back
		read_expect(crc_bus_pkg::REG_IDR, 32'h0, "IDR after reset");
		read_expect(crc_bus_pkg::REG_CR, 32'h0, "CR after reset");
		read_expect(crc_bus_pkg::REG_INIT, 32'hFFFF_FFFF, "INIT after reset");
		read_expect(crc_bus_pkg::REG_POL, 32'h04C1_1DB7, "POL after reset");
		read_expect(crc_bus_pkg::REG_DR, 32'hFFFF_FFFF, "DR after reset");
		read_expect(3'd3, 32'h0, "Unmapped word");
		write_reg(crc_bus_pkg::REG_IDR, crc_bus_pkg::WORD, 32'h1234_56A5);
		read_expect(crc_bus_pkg::REG_IDR, 32'h0000_00A5, "IDR write");
		r = $random(seed);
		write_poly(r);
		read_expect(crc_bus_pkg::REG_POL, r, "POL write");
		r = $random(seed);
		write_init(r);
		read_expect(crc_bus_pkg::REG_INIT, r, "INIT write");
		write_cfg(make_cfg(crc_cfg_pkg::P16, crc_cfg_pkg::HALF, 1'b1));
		read_expect(crc_bus_pkg::REG_CR, 32'h0000_00C8, "CR fields");
		read_expect(crc_bus_pkg::REG_DR, out_view(model_crc, model_cfg), "DR after INIT");
		write_cfg(make_cfg(crc_cfg_pkg::P32, crc_cfg_pkg::NONE, 1'b0));
		write_poly(32'h04C1_1DB7);
		write_init(32'hFFFF_FFFF);

		// Back-to-back words where later writes stall on the full buffer
		repeat (8)
		begin
			r = $random(seed);
			write_data(r, crc_bus_pkg::WORD);
		end
		read_expect(crc_bus_pkg::REG_DR, out_view(model_crc, model_cfg), "DR default CRC-32");

		// Every polynomial size with random polynomials and sizes
		for (int p = 0; p < 4; p++)
		begin
			write_cfg(make_cfg(crc_cfg_pkg::poly_size_e'(p[1:0]), crc_cfg_pkg::NONE, 1'b0));
			r = $random(seed);
			write_poly(r);
			r = $random(seed);
			write_init(r);
			repeat (6)
			begin
				r = $random(seed);
				write_data(r, random_size());
			end
			read_expect(crc_bus_pkg::REG_DR, out_view(model_crc, model_cfg), "DR poly size");
		end

		// Input and output reversal modes
		for (int ro = 0; ro < 2; ro++)
		begin
			for (int ri = 0; ri < 4; ri++)
			begin
				r = $random(seed);
				write_cfg(make_cfg(crc_cfg_pkg::poly_size_e'(r[1:0]),
					crc_cfg_pkg::rev_in_e'(ri[1:0]), ro[0]));
				r = $random(seed);
				write_init(r);
				repeat (4)
				begin
					r = $random(seed);
					write_data(r, random_size());
				end
				read_expect(crc_bus_pkg::REG_DR, out_view(model_crc, model_cfg), "DR reversal");
			end
		end

		// Chain reset right behind a data write so the data folds in first
		write_cfg(make_cfg(crc_cfg_pkg::P32, crc_cfg_pkg::NONE, 1'b0));
		r = $random(seed);
		write_init(r);
		r = $random(seed);
		write_data(r, crc_bus_pkg::WORD);
		write_reg(crc_bus_pkg::REG_CR, crc_bus_pkg::WORD, cr_word(model_cfg, 1'b1));
		model_crc = model_init;
		read_expect(crc_bus_pkg::REG_DR, out_view(model_crc, model_cfg), "DR after chain reset");
		// INIT write waits out the reload, then restarts from the new value
		r = $random(seed);
		write_data(r, crc_bus_pkg::WORD);
		write_reg(crc_bus_pkg::REG_CR, crc_bus_pkg::WORD, cr_word(model_cfg, 1'b1));
		r = $random(seed);
		write_init(r);
		r = $random(seed);
		write_data(r, crc_bus_pkg::WORD);
		read_expect(crc_bus_pkg::REG_DR, out_view(model_crc, model_cfg), "DR after INIT reload");

		// Let the compare process drain
		while (got_q.size() != 0)
			@(posedge HCLK);
		if (error_count == 0)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
		begin
			$display("Test failures found");
			$fatal(1, "Checks reported mismatches");
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the CRC peripheral testbench with Verilator
# The exit status is nonzero when the simulation ends in $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module crc_ahb_tb -f all.f -o crc_ahb_sim \
	&& ./obj_dir/crc_ahb_sim \
	|| exit 1

/* source/crc_ahb.sv */
// CRC peripheral with an AHB-Lite slave port
// HRESP is tied to OKAY and HSEL comes from an external decoder
module crc_ahb
(
	input  logic HCLK,
	input  logic HRESETn,
	input  logic HSEL,
	input  crc_bus_pkg::bus_word_t HADDR,
	input  crc_bus_pkg::htrans_t HTRANS,
	input  crc_bus_pkg::hsize_t HSIZE,
	input  logic HWRITE,
	input  crc_bus_pkg::bus_word_t HWDATA,
	input  logic HREADY,
	output crc_bus_pkg::bus_word_t HRDATA,
	output logic HREADYOUT,
	output logic HRESP
);

	// Host to datapath
	crc_bus_pkg::bus_word_t bus_wr;
	crc_bus_pkg::hsize_t bus_size;
	crc_cfg_pkg::crc_cfg_t cfg;
	logic buffer_write_en;
	logic crc_init_en;
	logic crc_poly_en;
	logic crc_idr_en;
	logic reset_chain;

	// Datapath back to host
	logic buffer_full;
	logic empty;
	logic reset_pending;
	logic read_wait;
	crc_cfg_pkg::feed_t feed;
	crc_cfg_pkg::crc_word_t crc_out;
	crc_cfg_pkg::crc_word_t crc_init_out;
	crc_cfg_pkg::crc_word_t crc_poly_out;
	crc_cfg_pkg::data_byte_t crc_idr_out;

	host_interface host_interface_i (.*);

	// Buffer only needs the input reversal mode
	crc_data_buffer crc_data_buffer_i
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.buffer_write_en (buffer_write_en),
		.rev_in          (cfg.rev_in),
		.buffer_full     (buffer_full),
		.empty           (empty),
		.feed            (feed)
	);

	crc_core crc_core_i (.*);

endmodule

/* source/crc_bus_pkg.sv */
// Bus-side definitions of the CRC peripheral
// Only the word address HADDR[4:2] is decoded and unmapped words read as zero
package crc_bus_pkg;

	////////////////////
	// AHB-Lite encodings
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Aligned sizes only
	typedef enum logic [2:0] {
		BYTE = 3'b000,
		HALF = 3'b001,
		WORD = 3'b010
	} hsize_t;

	// Slave never signals an error
	localparam logic HRESP_OKAY = 1'b0;

	typedef logic [31:0] bus_word_t;

	////////////////////
	// Register map at word granularity
	typedef logic [2:0] reg_addr_t;

	localparam reg_addr_t REG_DR   = 3'd0;
	localparam reg_addr_t REG_IDR  = 3'd1;
	localparam reg_addr_t REG_CR   = 3'd2;
	localparam reg_addr_t REG_INIT = 3'd4;
	localparam reg_addr_t REG_POL  = 3'd5;

	// CR field positions
	localparam int CR_RESET_BIT    = 0;
	localparam int CR_POLYSIZE_LSB = 3;
	localparam int CR_REVIN_LSB    = 5;
	localparam int CR_REVOUT_BIT   = 7;

endpackage

/* source/crc_cfg_pkg.sv */
// CRC configuration and datapath definitions
// Field order of crc_cfg_t matches CR[7:3] so the struct maps onto the register
package crc_cfg_pkg;

	////////////////////
	// Word types
	typedef logic [31:0] crc_word_t;
	typedef logic [7:0] data_byte_t;

	// Polynomial width select
	typedef enum logic [1:0] {
		P32 = 2'b00,
		P16 = 2'b01,
		P8  = 2'b10,
		P7  = 2'b11
	} poly_size_e;

	// Input bit reversal unit
	typedef enum logic [1:0] {
		NONE = 2'b00,
		BYTE = 2'b01,
		HALF = 2'b10,
		WORD = 2'b11
	} rev_in_e;

	// CR contents, rev_out in the MSB
	typedef struct packed {
		logic       rev_out;
		rev_in_e    rev_in;
		poly_size_e poly_size;
	} crc_cfg_t;

	// One byte handed from the buffer to the core
	typedef struct packed {
		logic       valid;
		data_byte_t data;
	} feed_t;

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		RUN    = 2'b01,
		RELOAD = 2'b10
	} core_state_e;

	////////////////////
	// Reset values
	localparam crc_word_t INIT_RESET = 32'hFFFF_FFFF;
	localparam crc_word_t POLY_RESET = 32'h04C1_1DB7;
	localparam data_byte_t IDR_RESET = 8'h00;
	localparam crc_cfg_t CR_RESET = '0;

endpackage

/* source/crc_core.sv */
// Byte-serial CRC engine with the INIT, POL and IDR registers
// CRC lives in the low bits of the state; narrow sizes ignore upper INIT and POL bits
// An INIT write loads the CRC at once, bytes still in flight fold onto it
module crc_core
(
	input  logic HCLK,
	input  logic HRESETn,
	input  crc_cfg_pkg::feed_t feed,
	input  logic empty,
	input  crc_bus_pkg::bus_word_t bus_wr,
	input  logic crc_init_en,
	input  logic crc_poly_en,
	input  logic crc_idr_en,
	input  logic reset_chain,
	input  crc_cfg_pkg::crc_cfg_t cfg,
	output crc_cfg_pkg::crc_word_t crc_out,
	output crc_cfg_pkg::crc_word_t crc_init_out,
	output crc_cfg_pkg::crc_word_t crc_poly_out,
	output crc_cfg_pkg::data_byte_t crc_idr_out,
	output logic reset_pending,
	output logic read_wait
);

	crc_cfg_pkg::crc_word_t crc_q;
	crc_cfg_pkg::crc_word_t init_q;
	crc_cfg_pkg::crc_word_t poly_q;
	crc_cfg_pkg::data_byte_t idr_q;
	crc_cfg_pkg::core_state_e state_q;
	crc_cfg_pkg::core_state_e state_d;
	crc_cfg_pkg::crc_word_t width_mask;
	crc_cfg_pkg::crc_word_t crc_masked;
	crc_cfg_pkg::crc_word_t crc_flip;
	logic [4:0] rev_shift;

	// Eight serial steps, feedback from the top bit of the selected width
	function automatic crc_cfg_pkg::crc_word_t fold_byte(
		input crc_cfg_pkg::crc_word_t crc,
		input crc_cfg_pkg::data_byte_t data,
		input crc_cfg_pkg::crc_word_t poly,
		input crc_cfg_pkg::crc_word_t mask
	);
		crc_cfg_pkg::crc_word_t c;
		crc_cfg_pkg::crc_word_t top;
		logic fb;
		c   = crc & mask;
		top = mask ^ (mask >> 1);
		for (int i = 7; i >= 0; i--)
		begin
			fb = ((c & top) != '0) ^ data[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	// Width mask and the shift that right-aligns a reversed value
	always_comb
	begin
		case (cfg.poly_size)
			crc_cfg_pkg::P16:
			begin
				width_mask = 32'h0000_FFFF;
				rev_shift  = 5'd16;
			end
			crc_cfg_pkg::P8:
			begin
				width_mask = 32'h0000_00FF;
				rev_shift  = 5'd24;
			end
			crc_cfg_pkg::P7:
			begin
				width_mask = 32'h0000_007F;
				rev_shift  = 5'd25;
			end
			default:
			begin
				width_mask = 32'hFFFF_FFFF;
				rev_shift  = 5'd0;
			end
		endcase
	end

	////////////////////
	// Core FSM
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			crc_cfg_pkg::IDLE:
				if (reset_chain)
					state_d = crc_cfg_pkg::RELOAD;
				else if (feed.valid)
					state_d = crc_cfg_pkg::RUN;
			crc_cfg_pkg::RUN:
				if (reset_chain)
					state_d = crc_cfg_pkg::RELOAD;
				else if (!feed.valid)
					state_d = crc_cfg_pkg::IDLE;
			// Wait for buffered data to drain before reloading
			crc_cfg_pkg::RELOAD:
				if (empty)
					state_d = crc_cfg_pkg::IDLE;
			default: state_d = crc_cfg_pkg::IDLE;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_q <= crc_cfg_pkg::IDLE;
			crc_q   <= crc_cfg_pkg::INIT_RESET;
			init_q  <= crc_cfg_pkg::INIT_RESET;
			poly_q  <= crc_cfg_pkg::POLY_RESET;
			idr_q   <= crc_cfg_pkg::IDR_RESET;
		end
		else
		begin
			state_q <= state_d;
			if (crc_init_en)
				init_q <= bus_wr;
			if (crc_poly_en)
				poly_q <= bus_wr;
			if (crc_idr_en)
				idr_q <= bus_wr[7:0];
			// CRC source priority is INIT write, chain reload, then data
			if (crc_init_en)
				crc_q <= bus_wr;
			else if (state_q == crc_cfg_pkg::RELOAD && empty)
				crc_q <= init_q;
			else if (feed.valid)
				crc_q <= fold_byte(crc_q, feed.data, poly_q, width_mask);
		end
	end

	// Output reversal across the selected width, zero-extended
	always_comb
	begin
		crc_masked = crc_q & width_mask;
		for (int i = 0; i < 32; i++)
			crc_flip[i] = crc_masked[31 - i];
		crc_out = cfg.rev_out ? (crc_flip >> rev_shift) : crc_masked;
	end

	assign crc_init_out  = init_q;
	assign crc_poly_out  = poly_q;
	assign crc_idr_out   = idr_q;
	assign reset_pending = (state_q == crc_cfg_pkg::RELOAD);
	assign read_wait     = !empty || (state_q != crc_cfg_pkg::IDLE);

endmodule

/* source/crc_data_buffer.sv */
// One-entry DR buffer that feeds the core one byte per cycle, MSB first
// Input reversal never spans more than the written width
module crc_data_buffer
(
	input  logic HCLK,
	input  logic HRESETn,
	input  crc_bus_pkg::bus_word_t bus_wr,
	input  crc_bus_pkg::hsize_t bus_size,
	input  logic buffer_write_en,
	input  crc_cfg_pkg::rev_in_e rev_in,
	output logic buffer_full,
	output logic empty,
	output crc_cfg_pkg::feed_t feed
);

	// Bytes still to be handed out
	logic [2:0] count_q;
	logic [2:0] load_count;
	logic [1:0] byte_sel;
	crc_bus_pkg::bus_word_t data_q;
	crc_bus_pkg::bus_word_t written;
	crc_bus_pkg::bus_word_t by_byte;
	crc_bus_pkg::bus_word_t by_half;
	crc_bus_pkg::bus_word_t by_word;
	crc_bus_pkg::bus_word_t reversed;

	// Keep only the written low bytes
	always_comb
	begin
		case (bus_size)
			crc_bus_pkg::BYTE:
			begin
				written    = {24'h0, bus_wr[7:0]};
				load_count = 3'd1;
			end
			crc_bus_pkg::HALF:
			begin
				written    = {16'h0, bus_wr[15:0]};
				load_count = 3'd2;
			end
			default:
			begin
				written    = bus_wr;
				load_count = 3'd4;
			end
		endcase
	end

	////////////////////
	// Input bit reversal
	always_comb
	begin
		for (int i = 0; i < 32; i++)
		begin
			by_byte[i] = written[(i & ~7) | (7 - (i & 7))];
			by_half[i] = written[(i & ~15) | (15 - (i & 15))];
			by_word[i] = written[31 - i];
		end
		// Clip the reversal unit to the transfer size
		case (rev_in)
			crc_cfg_pkg::BYTE: reversed = by_byte;
			crc_cfg_pkg::HALF: reversed = (bus_size == crc_bus_pkg::BYTE) ? by_byte : by_half;
			crc_cfg_pkg::WORD:
			begin
				if (bus_size == crc_bus_pkg::BYTE)
					reversed = by_byte;
				else if (bus_size == crc_bus_pkg::HALF)
					reversed = by_half;
				else
					reversed = by_word;
			end
			default: reversed = written;
		endcase
	end

	// Host stalls DR writes while bytes remain, so a load never overlaps output
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count_q <= 3'd0;
		else if (buffer_write_en)
			count_q <= load_count;
		else if (count_q != 3'd0)
			count_q <= count_q - 3'd1;
	end

	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
			data_q <= reversed;
	end

	// Count of 4 wraps to byte 3, the most significant one
	assign byte_sel = count_q[1:0] - 2'd1;

	assign feed.valid  = (count_q != 3'd0);
	assign feed.data   = data_q[{byte_sel, 3'b000} +: 8];
	assign buffer_full = (count_q != 3'd0);
	assign empty       = (count_q == 3'd0);

endmodule

/* source/host_interface.sv */
// AHB-Lite slave front end of the CRC peripheral
// Single NONSEQ transfers only; SEQ and BUSY are treated as idle
// Write strobes pulse once in the completing data-phase cycle
module host_interface
(
	input  logic HCLK,
	input  logic HRESETn,
	input  logic HSEL,
	input  crc_bus_pkg::bus_word_t HADDR,
	input  crc_bus_pkg::htrans_t HTRANS,
	input  crc_bus_pkg::hsize_t HSIZE,
	input  logic HWRITE,
	input  crc_bus_pkg::bus_word_t HWDATA,
	input  logic HREADY,
	input  crc_cfg_pkg::crc_word_t crc_out,
	input  crc_cfg_pkg::crc_word_t crc_init_out,
	input  crc_cfg_pkg::crc_word_t crc_poly_out,
	input  crc_cfg_pkg::data_byte_t crc_idr_out,
	input  logic buffer_full,
	input  logic reset_pending,
	input  logic read_wait,
	output crc_bus_pkg::bus_word_t HRDATA,
	output logic HREADYOUT,
	output logic HRESP,
	output crc_bus_pkg::bus_word_t bus_wr,
	output crc_bus_pkg::hsize_t bus_size,
	output crc_cfg_pkg::crc_cfg_t cfg,
	output logic buffer_write_en,
	output logic crc_init_en,
	output logic crc_poly_en,
	output logic crc_idr_en,
	output logic reset_chain
);

	// Address phase captured for the data phase
	logic hsel_pp;
	crc_bus_pkg::reg_addr_t haddr_pp;
	crc_bus_pkg::htrans_t htrans_pp;
	crc_bus_pkg::hsize_t hsize_pp;
	logic hwrite_pp;

	logic sample_bus;
	logic active;
	logic write_en;
	logic read_en;
	logic dr_sel;
	logic init_sel;
	logic stall;
	logic crc_cr_en;
	crc_bus_pkg::bus_word_t cr_rd;

	////////////////////
	// Address phase pipeline

	// Bus is sampled only when no data phase is stalled
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hsel_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			hsel_pp <= HSEL;
		end
	end

	// Rest of the address phase only matters while hsel_pp is set
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			htrans_pp <= HTRANS;
			hsize_pp  <= HSIZE;
			hwrite_pp <= HWRITE;
		end
	end

	// Only NONSEQ starts a transfer
	assign active   = hsel_pp && (htrans_pp == crc_bus_pkg::NONSEQ);
	assign write_en = active && hwrite_pp;
	assign read_en  = active && !hwrite_pp;

	assign dr_sel   = (haddr_pp == crc_bus_pkg::REG_DR);
	assign init_sel = (haddr_pp == crc_bus_pkg::REG_INIT);

	////////////////////
	// Wait states

	// DR write waits for the buffer, DR read for the pipeline to drain
	// INIT write waits for a chain reset to finish
	assign stall = (dr_sel && write_en && buffer_full) ||
	               (dr_sel && read_en && read_wait) ||
	               (init_sel && write_en && reset_pending);

	assign HREADYOUT = !stall;
	assign HRESP     = crc_bus_pkg::HRESP_OKAY;

	// Strobes fire in the completing cycle only
	assign buffer_write_en = write_en && HREADYOUT && dr_sel;
	assign crc_init_en     = write_en && HREADYOUT && init_sel;
	assign crc_poly_en     = write_en && HREADYOUT && (haddr_pp == crc_bus_pkg::REG_POL);
	assign crc_idr_en      = write_en && HREADYOUT && (haddr_pp == crc_bus_pkg::REG_IDR);
	assign crc_cr_en       = write_en && HREADYOUT && (haddr_pp == crc_bus_pkg::REG_CR);

	// Write data is not registered here
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	// One-cycle chain reset from CR bit 0
	assign reset_chain = crc_cr_en && HWDATA[crc_bus_pkg::CR_RESET_BIT];

	// Control register
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			cfg <= crc_cfg_pkg::CR_RESET;
		end
		else if (crc_cr_en)
		begin
			cfg.poly_size <= crc_cfg_pkg::poly_size_e'(HWDATA[crc_bus_pkg::CR_POLYSIZE_LSB +: 2]);
			cfg.rev_in    <= crc_cfg_pkg::rev_in_e'(HWDATA[crc_bus_pkg::CR_REVIN_LSB +: 2]);
			cfg.rev_out   <= HWDATA[crc_bus_pkg::CR_REVOUT_BIT];
		end
	end

	////////////////////
	// Read data

	// CR fields back at their write positions, reset bit reads zero
	always_comb
	begin
		cr_rd = '0;
		cr_rd[crc_bus_pkg::CR_POLYSIZE_LSB +: 2] = cfg.poly_size;
		cr_rd[crc_bus_pkg::CR_REVIN_LSB +: 2]    = cfg.rev_in;
		cr_rd[crc_bus_pkg::CR_REVOUT_BIT]        = cfg.rev_out;
	end

	always_comb
	begin
		case (haddr_pp)
			crc_bus_pkg::REG_DR:   HRDATA = crc_out;
			crc_bus_pkg::REG_IDR:  HRDATA = {24'h0, crc_idr_out};
			crc_bus_pkg::REG_CR:   HRDATA = cr_rd;
			crc_bus_pkg::REG_INIT: HRDATA = crc_init_out;
			crc_bus_pkg::REG_POL:  HRDATA = crc_poly_out;
			default:               HRDATA = '0;
		endcase
	end

endmodule
